//--- hw/cpu_pkg.sv
// Shared widths, vector types, opcodes, control-word bit indices, idle word, sequencer states
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;  // Bus and register width
    localparam int ADDR_W = 4;  // 16-byte address space
    localparam int OP_W   = 4;  // Upper instruction nibble
    localparam int CW_W   = 15; // Control word width

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [OP_W-1:0]   opcode_t;
    typedef logic [CW_W-1:0]   control_word_t;

    // Instruction set, anything else runs as a NOP
    localparam opcode_t OP_LDA = 4'd0;
    localparam opcode_t OP_ADD = 4'd1;
    localparam opcode_t OP_SUB = 4'd2;
    localparam opcode_t OP_JMP = 4'd3;
    localparam opcode_t OP_JC  = 4'd4;
    localparam opcode_t OP_JZ  = 4'd5;
    localparam opcode_t OP_OUT = 4'd14;
    localparam opcode_t OP_HLT = 4'd15;

    // Control word bit positions, MSB first
    localparam int CB_CP   = 14; // PC count
    localparam int CB_EP   = 13; // PC onto bus
    localparam int CB_LP   = 12; // PC load from bus
    localparam int CB_NLMA = 11; // MAR load, active low
    localparam int CB_NLMD = 10; // Memory data latch, active low
    localparam int CB_NCE  = 9;  // RAM onto bus, active low
    localparam int CB_NLR  = 8;  // RAM write, active low
    localparam int CB_NLI  = 7;  // IR load, active low
    localparam int CB_NEI  = 6;  // IR operand onto bus, active low
    localparam int CB_NLA  = 5;  // Accumulator load, active low
    localparam int CB_EA   = 4;  // Accumulator onto bus
    localparam int CB_SUB  = 3;  // ALU subtract select
    localparam int CB_EU   = 2;  // ALU onto bus
    localparam int CB_NLB  = 1;  // B register load, active low
    localparam int CB_NLO  = 0;  // Output register load, active low

    // All active-low strobes high, all active-high strobes low
    localparam control_word_t CW_IDLE = 15'h0FE3;

    // Ring counter steps plus a parking state for HLT
    typedef enum logic [2:0] {T1, T2, T3, T4, T5, T6, HALTED} ring_state_t;

endpackage

`default_nettype wire

//--- hw/program_counter.sv
// 4-bit program counter with count, bus load and bus-enable pass-through
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  logic            clk,
    input  logic            reset,
    input  logic            run,          // Low holds the counter at zero
    input  logic            cp,           // Count up
    input  logic            ep,           // Drive bus
    input  logic            lp,           // Load from bus
    input  cpu_pkg::data_t  bus_in,
    output cpu_pkg::addr_t  count,
    output logic            count_enable
);
    import cpu_pkg::*;

    // Load wins over count, a jump never coincides with Cp anyway
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            count <= '0;                          // Restart from address 0
        end else if (lp) begin
            count <= bus_in[ADDR_W-1:0];          // Jump target from IR operand
        end else if (cp) begin
            count <= count + addr_t'(1);          // Wraps at 15
        end
    end

    // Top level muxes the bus with this
    assign count_enable = ep;

endmodule

`default_nettype wire

//--- hw/control_block.sv
// Six-step ring sequencer, opcode and flag decode into the control word, halt state
`timescale 1ns/1ps
`default_nettype none

module control_block (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  cpu_pkg::opcode_t       opcode,
    input  logic                   carry_flag,
    input  logic                   zero_flag,
    output cpu_pkg::control_word_t control_word,
    output logic                   halted
);
    import cpu_pkg::*;

    ring_state_t   state;
    ring_state_t   next_state;
    logic          run_q;      // Run seen on the previous edge
    logic          active;     // Sequencer allowed to issue strobes
    logic          is_arith;
    control_word_t cw;

    assign is_arith = (opcode == OP_ADD) || (opcode == OP_SUB);

    // First cycle after run rises stays idle, also idle right after reset
    assign active = run && run_q;

    always_comb begin
        case (state)
            T1:      next_state = T2;
            T2:      next_state = T3;
            T3:      next_state = T4;
            T4:      next_state = (opcode == OP_HLT) ? HALTED : T5;
            T5:      next_state = T6;
            T6:      next_state = T1;
            HALTED:  next_state = HALTED;   // Left only by reset or load mode
            default: next_state = T1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= T1;
            run_q <= 1'b0;
        end else begin
            run_q <= run;
            if (!run) begin
                state <= T1;                // Load mode parks at fetch
            end else if (run_q) begin
                state <= next_state;
            end
        end
    end

    // Word decode, starts from idle and flips only the strobes needed
    always_comb begin
        cw = CW_IDLE;
        if (active) begin
            case (state)
                T1: begin
                    cw[CB_EP]   = 1'b1;     // PC onto bus
                    cw[CB_NLMA] = 1'b0;     // MAR takes it
                end
                T2: begin
                    cw[CB_CP] = 1'b1;       // Advance PC
                end
                T3: begin
                    cw[CB_NCE] = 1'b0;      // Instruction byte onto bus
                    cw[CB_NLI] = 1'b0;      // IR takes it
                end
                T4: begin
                    if (opcode == OP_LDA || is_arith) begin
                        cw[CB_NEI]  = 1'b0; // Operand address to MAR
                        cw[CB_NLMA] = 1'b0;
                    end else if (opcode == OP_OUT) begin
                        cw[CB_EA]  = 1'b1;
                        cw[CB_NLO] = 1'b0;
                    end else if (opcode == OP_JMP) begin
                        cw[CB_NEI] = 1'b0;
                        cw[CB_LP]  = 1'b1;
                    end else if (opcode == OP_JC) begin
                        cw[CB_NEI] = 1'b0;
                        cw[CB_LP]  = carry_flag;    // Taken only on carry
                    end else if (opcode == OP_JZ) begin
                        cw[CB_NEI] = 1'b0;
                        cw[CB_LP]  = zero_flag;     // Taken only on zero
                    end
                end
                T5: begin
                    if (opcode == OP_LDA) begin
                        cw[CB_NCE] = 1'b0;
                        cw[CB_NLA] = 1'b0;  // Memory straight into A
                    end else if (is_arith) begin
                        cw[CB_NCE] = 1'b0;
                        cw[CB_NLB] = 1'b0;  // Operand into B
                    end
                end
                T6: begin
                    if (is_arith) begin
                        cw[CB_EU]  = 1'b1;  // ALU result onto bus, flags latch
                        cw[CB_NLA] = 1'b0;
                        cw[CB_SUB] = (opcode == OP_SUB);
                    end
                end
                default: cw = CW_IDLE;      // Halted
            endcase
        end
    end

    assign control_word = cw;
    assign halted       = (state == HALTED);

endmodule

`default_nettype wire

//--- hw/alu.sv
// 8-bit add/subtract unit with latched carry and zero flags
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::data_t reg_a,
    input  cpu_pkg::data_t reg_b,
    input  logic           sub,        // 1 selects a - b
    input  logic           eu,         // Result on bus, flags latch
    output cpu_pkg::data_t result,
    output logic           carry_flag,
    output logic           zero_flag
);
    import cpu_pkg::*;

    logic [DATA_W:0] sum;       // Extra bit is carry out
    data_t           operand_b;

    // Two's complement subtract, invert here and add one below
    assign operand_b = sub ? ~reg_b : reg_b;

    // Carry set on SUB means no borrow
    assign sum    = {1'b0, reg_a} + {1'b0, operand_b} + {{DATA_W{1'b0}}, sub};
    assign result = sum[DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            carry_flag <= 1'b0;
            zero_flag  <= 1'b0;
        end else if (eu) begin
            carry_flag <= sum[DATA_W];
            zero_flag  <= (sum[DATA_W-1:0] == '0);
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_registers.sv
// Accumulator, B register, instruction register and output register loaded from the bus
`timescale 1ns/1ps
`default_nettype none

module cpu_registers (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::data_t   bus,
    input  logic             n_load_a,   // Active low strobes
    input  logic             n_load_b,
    input  logic             n_load_i,
    input  logic             n_load_o,
    output cpu_pkg::data_t   reg_a,
    output cpu_pkg::data_t   reg_b,
    output cpu_pkg::data_t   out_value,
    output cpu_pkg::opcode_t opcode,
    output cpu_pkg::addr_t   operand
);
    import cpu_pkg::*;

    data_t acc_q;
    data_t b_q;
    data_t ir_q;
    data_t out_q;

    // Accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q <= '0;
        end else if (!n_load_a) begin
            acc_q <= bus;           // LDA or ALU write-back
        end
    end

    // B register, second ALU operand
    always_ff @(posedge clk) begin
        if (reset) begin
            b_q <= '0;
        end else if (!n_load_b) begin
            b_q <= bus;
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (reset) begin
            ir_q <= '0;
        end else if (!n_load_i) begin
            ir_q <= bus;            // Fetched in T3
        end
    end

    // Output register, holds its value until the next OUT
    always_ff @(posedge clk) begin
        if (reset) begin
            out_q <= '0;
        end else if (!n_load_o) begin
            out_q <= bus;
        end
    end

    assign reg_a     = acc_q;
    assign reg_b     = b_q;
    assign out_value = out_q;

    // Upper nibble decodes, lower nibble is the address field
    assign opcode  = ir_q[DATA_W-1:ADDR_W];
    assign operand = ir_q[ADDR_W-1:0];

endmodule

`default_nettype wire

//--- hw/program_memory.sv
// Memory address register and 16x8 RAM with load-mode write port and combinational read
`timescale 1ns/1ps
`default_nettype none

module program_memory (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::data_t bus,
    input  logic           n_load_addr,  // MAR strobe, active low
    input  logic           prog_write,   // Load-mode write enable
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::data_t prog_data,
    output cpu_pkg::data_t read_data
);
    import cpu_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;  // 16 bytes shared by program and data

    addr_t mar;
    data_t mem [DEPTH];

    // MAR takes the low bus nibble from PC or IR operand
    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
        end else if (!n_load_addr) begin
            mar <= bus[ADDR_W-1:0];
        end
    end

    // Load-mode write port
    always_ff @(posedge clk) begin
        if (prog_write) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Read valid in the cycle after MAR loads
    assign read_data = mem[mar];

endmodule

`default_nettype wire

//--- hw/sap_cpu_top.sv
// CPU top level with bus multiplexer, pin mapping and all block instances
`timescale 1ns/1ps
`default_nettype none

module sap_cpu_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           ena,       // Always high when powered, not used
    input  cpu_pkg::data_t ui_in,     // Load-mode write data
    input  cpu_pkg::data_t uio_in,    // Run, write strobe, write address
    output cpu_pkg::data_t uo_out,
    output cpu_pkg::data_t uio_out,
    output cpu_pkg::data_t uio_oe
);
    import cpu_pkg::*;

    data_t         bus;
    control_word_t control_word;
    logic          run;
    logic          prog_write;
    logic          halted;
    addr_t         pc_count;
    logic          pc_bus_en;
    opcode_t       opcode;
    addr_t         operand;
    data_t         reg_a;
    data_t         reg_b;
    data_t         alu_result;
    data_t         ram_data;
    data_t         out_value;
    logic          carry_flag;
    logic          zero_flag;

    assign run        = uio_in[7];
    assign prog_write = uio_in[4] && !run;   // Writes only in load mode

    program_counter pc_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .cp           (control_word[CB_CP]),
        .ep           (control_word[CB_EP]),
        .lp           (control_word[CB_LP]),
        .bus_in       (bus),
        .count        (pc_count),
        .count_enable (pc_bus_en)
    );

    control_block control_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .opcode       (opcode),
        .carry_flag   (carry_flag),
        .zero_flag    (zero_flag),
        .control_word (control_word),
        .halted       (halted)
    );

    alu alu_i (
        .clk        (clk),
        .reset      (reset),
        .reg_a      (reg_a),
        .reg_b      (reg_b),
        .sub        (control_word[CB_SUB]),
        .eu         (control_word[CB_EU]),
        .result     (alu_result),
        .carry_flag (carry_flag),
        .zero_flag  (zero_flag)
    );

    cpu_registers regs_i (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .n_load_a  (control_word[CB_NLA]),
        .n_load_b  (control_word[CB_NLB]),
        .n_load_i  (control_word[CB_NLI]),
        .n_load_o  (control_word[CB_NLO]),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .out_value (out_value),
        .opcode    (opcode),
        .operand   (operand)
    );

    program_memory mem_i (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus),
        .n_load_addr (control_word[CB_NLMA]),
        .prog_write  (prog_write),
        .prog_addr   (uio_in[3:0]),
        .prog_data   (ui_in),
        .read_data   (ram_data)
    );

    // AND-OR bus mux, stands in for the tri-state drivers; zero when nobody drives
    assign bus = ({DATA_W{pc_bus_en}}              & {4'b0, pc_count})
               | ({DATA_W{!control_word[CB_NEI]}}  & {4'b0, operand})
               | ({DATA_W{control_word[CB_EA]}}    & reg_a)
               | ({DATA_W{control_word[CB_EU]}}    & alu_result)
               | ({DATA_W{!control_word[CB_NCE]}}  & ram_data);

    assign uo_out = out_value;
    assign uio_out = {halted, control_word[CB_CP], control_word[CB_EP], control_word[CB_LP],
                      2'b00, carry_flag, zero_flag};
    assign uio_oe = 8'hFF;                   // All bidirectional pins driven out

endmodule

`default_nettype wire

//--- test/sap_cpu_chk.sv
// Bound assertions for bus-driver exclusivity, idle word while halted and post-reset outputs
`timescale 1ns/1ps
`default_nettype none

module sap_cpu_chk (
    input logic                   clk,
    input logic                   reset,
    input cpu_pkg::control_word_t control_word,
    input logic                   halted,
    input logic                   pc_bus_en,
    input cpu_pkg::data_t         uo_out,
    input cpu_pkg::data_t         uio_out
);
    import cpu_pkg::*;

    logic [4:0] bus_drivers;    // One bit per bus source
    int         fail_count = 0; // Assertion failures so far, read by the testbench

    assign bus_drivers = {pc_bus_en, !control_word[CB_NEI], control_word[CB_EA],
                          control_word[CB_EU], !control_word[CB_NCE]};

    // Two sources at once would be a bus conflict
    single_driver: assert property (@(posedge clk) disable iff (reset)
        $onehot0(bus_drivers))
        else begin
            fail_count++;
            $error("more than one bus driver enabled: %b", bus_drivers);
        end

    // Parked sequencer issues no strobes
    halt_idle: assert property (@(posedge clk) disable iff (reset)
        halted |-> (control_word == CW_IDLE))
        else begin
            fail_count++;
            $error("control word %h not idle while halted", control_word);
        end

    // First edge after reset release
    reset_outputs: assert property (@(posedge clk)
        $fell(reset) |-> (uo_out == '0) && (uio_out == '0))
        else begin
            fail_count++;
            $error("outputs not zero after reset: uo_out %h uio_out %h",
                   uo_out, uio_out);
        end

endmodule

bind sap_cpu_top sap_cpu_chk chk_i (
    .clk          (clk),
    .reset        (reset),
    .control_word (control_word),
    .halted       (halted),
    .pc_bus_en    (pc_bus_en),
    .uo_out       (uo_out),
    .uio_out      (uio_out)
);

`default_nettype wire

//--- test/sap_cpu_tb.sv
// CPU testbench with clock, reset, LFSR, test table, program loader, run loop, checks, timeout
`timescale 1ns/1ps
`default_nettype none

module sap_cpu_tb;
    import cpu_pkg::*;

    typedef enum logic [1:0] {ARITH, JUMP_C, JUMP_Z} row_kind_t;

    localparam int ROWS        = 19;    // 7 fixed plus 12 random
    localparam int RESET_LEN   = 16;
    localparam int HOLD_CYCLES = 20;
    localparam int ROW_CYCLES  = 100;   // Load 18, run under 40, hold 20
    localparam int MAX_CYCLES  = ROWS * ROW_CYCLES + RESET_LEN + 8;

    logic  clk = 1'b0;
    logic  reset;
    logic  ena;
    data_t ui_in;
    data_t uio_in;
    data_t uo_out;
    data_t uio_out;
    data_t uio_oe;

    // Stimulus and expected results per program run
    row_kind_t row_kind  [ROWS];
    opcode_t   row_op    [ROWS];
    data_t     row_a     [ROWS];
    data_t     row_b     [ROWS];
    data_t     row_mark  [ROWS];    // Shown only on the fall-through path
    data_t     exp_out   [ROWS];
    logic      exp_carry [ROWS];
    logic      exp_zero  [ROWS];

    data_t       image [16];        // Program image for the current row
    int          row_count   = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr;

    sap_cpu_top sap_cpu_i (
        .clk     (clk),
        .reset   (reset),
        .ena     (ena),
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe)
    );

    always #50 clk = ~clk;          // 100 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped: cycle limit of %0d reached before the tests finished",
                     MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // Bound checker failures end the run at once
    always @(negedge clk) begin
        if (sap_cpu_i.chk_i.fail_count != 0) begin
            $display("Bound checker flagged %0d assertion failures",
                     sap_cpu_i.chk_i.fail_count);
            $display("Verification failed");
            $fatal(1, "assertion failure");
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
        end
        return n;
    endfunction

    task automatic draw_bit(output logic bit_out);
        lfsr    = lfsr_step(lfsr);
        bit_out = lfsr[0];
    endtask

    task automatic draw_byte(output data_t v);
        logic b;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            draw_bit(b);
            v = {v[6:0], b};        // MSB first
        end
    endtask

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;                         // Inputs change 1 ns after the edge
    endtask

    // Expected values from the instruction rules
    task automatic add_row(input row_kind_t kind, input opcode_t op,
                           input data_t a, input data_t b);
        logic [8:0] sum9;
        logic       taken;
        if (op == OP_ADD) begin
            sum9 = {1'b0, a} + {1'b0, b};
        end else begin
            sum9 = {1'b0, a} + {1'b0, ~b} + 9'd1;   // Carry means no borrow
        end
        row_kind[row_count]  = kind;
        row_op[row_count]    = op;
        row_a[row_count]     = a;
        row_b[row_count]     = b;
        row_mark[row_count]  = ~sum9[7:0];          // Never equal to the result
        exp_carry[row_count] = sum9[8];
        exp_zero[row_count]  = (sum9[7:0] == 8'h00);
        taken = (kind == JUMP_C) ? sum9[8] : (sum9[7:0] == 8'h00);
        exp_out[row_count]   = (kind == ARITH || taken) ? sum9[7:0] : ~sum9[7:0];
        row_count++;
    endtask

    task automatic build_image(input int r);
        opcode_t jump_op;
        jump_op = (row_kind[r] == JUMP_C) ? OP_JC : OP_JZ;
        for (int i = 0; i < 16; i++) begin
            image[i] = {OP_HLT, addr_t'(i)};        // Stray paths halt
        end
        image[0] = {OP_LDA, 4'd14};
        image[1] = {row_op[r], 4'd15};
        if (row_kind[r] == ARITH) begin
            image[2] = {OP_OUT, 4'd0};
            image[3] = {OP_HLT, 4'd0};
        end else begin
            image[2] = {jump_op, 4'd6};
            image[3] = {OP_LDA, 4'd13};             // Fall-through loads the marker
            image[4] = {OP_OUT, 4'd0};
            image[5] = {OP_HLT, 4'd0};
            image[6] = {OP_OUT, 4'd0};              // Taken path shows the result
            image[7] = {OP_HLT, 4'd0};
        end
        image[13] = row_mark[r];
        image[14] = row_a[r];
        image[15] = row_b[r];
    endtask

    task automatic load_program;
        uio_in = 8'h00;                             // Run low parks the CPU in T1
        next_cycle();
        check_value("halted", {7'b0, uio_out[7]}, 8'h00);
        for (int i = 0; i < 16; i++) begin
            ui_in  = image[i];
            uio_in = {3'b000, 1'b1, addr_t'(i)};    // Write strobe plus address
            next_cycle();
        end
        ui_in  = 8'h00;
        uio_in = 8'h00;
        next_cycle();
    endtask

    task automatic run_and_check(input int r);
        uio_in = 8'h80;                             // Start at address 0
        do begin
            next_cycle();
        end while (uio_out[7] !== 1'b1);
        check_value("uo_out", uo_out, exp_out[r]);
        check_value("carry", {7'b0, uio_out[1]}, {7'b0, exp_carry[r]});
        check_value("zero", {7'b0, uio_out[0]}, {7'b0, exp_zero[r]});
        repeat (HOLD_CYCLES) begin
            next_cycle();
            check_value("halted", {7'b0, uio_out[7]}, 8'h01);
            check_value("uo_out", uo_out, exp_out[r]);
        end
    endtask

    initial begin
        data_t a;
        data_t b;
        logic  pick;
        reset  = 1'b1;
        ena    = 1'b1;
        ui_in  = 8'h00;
        uio_in = 8'h00;
        lfsr   = 32'h9814;

        // Corner cases
        add_row(ARITH, OP_ADD, 8'h00, 8'h00);
        add_row(ARITH, OP_ADD, 8'hFF, 8'h01);
        add_row(ARITH, OP_SUB, 8'h05, 8'h05);
        add_row(ARITH, OP_SUB, 8'h03, 8'h05);
        add_row(JUMP_C, OP_ADD, 8'hFF, 8'h01);      // Carry takes the jump
        add_row(JUMP_Z, OP_SUB, 8'h05, 8'h05);      // Zero takes the jump
        add_row(JUMP_Z, OP_SUB, 8'h03, 8'h05);      // Falls through
        for (int i = 0; i < 12; i++) begin
            draw_byte(a);
            draw_byte(b);
            draw_bit(pick);
            case (i % 3)
                0:       add_row(ARITH, pick ? OP_SUB : OP_ADD, a, b);
                1:       add_row(JUMP_C, OP_ADD, a, b);
                default: add_row(JUMP_Z, OP_SUB, a, pick ? a : b);  // Some hit zero
            endcase
        end

        repeat (RESET_LEN) @(posedge clk);
        #1 reset = 1'b0;
        check_value("uo_out", uo_out, 8'h00);
        check_value("uio_out", uio_out, 8'h00);     // Halted, Cp, Ep, Lp, flags
        check_value("uio_oe", uio_oe, 8'hFF);

        for (int r = 0; r < ROWS; r++) begin
            build_image(r);
            load_program();                         // Also restarts after HLT
            run_and_check(r);
        end

        if (sap_cpu_i.chk_i.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Bound checker flagged %0d assertion failures",
                     sap_cpu_i.chk_i.fail_count);
            $display("Verification failed");
            $fatal(1, "assertion failure");
        end
    end

endmodule

`default_nettype wire

//--- all.f
hw/cpu_pkg.sv
hw/program_counter.sv
hw/control_block.sv
hw/alu.sv
hw/cpu_registers.sv
hw/program_memory.sv
hw/sap_cpu_top.sv
test/sap_cpu_chk.sv
test/sap_cpu_tb.sv
